// ==== hw/heapPkg.sv ====
/*
  Array heap package: sizes, action and error codes,
  ALU operations and the element types shared by all blocks
*/
`default_nettype none

package heapPkg;

  // ------------------------------
  // Sizes
  localparam int ADDRESS_BITS = 3;                    // Bits in an array number
  localparam int INDEX_BITS   = 3;                    // Bits in an element index
  localparam int DATA_BITS    = 16;                   // Element width
  localparam int ARRAYS       = 2 ** ADDRESS_BITS;    // 8 arrays
  localparam int ARRAY_LENGTH = 2 ** INDEX_BITS;      // 8 elements per array

  typedef logic [ADDRESS_BITS-1:0] arrayIdT;          // Array number
  typedef logic [INDEX_BITS-1:0]   indexT;            // Element index
  typedef logic [INDEX_BITS:0]     sizeT;             // Size 0 .. ARRAY_LENGTH
  typedef logic [DATA_BITS-1:0]    dataT;             // Element word

  // ------------------------------
  // Command codes
  typedef enum logic [7:0] {
    actReset      = 8'd1,                             // Clear both counters
    actWrite      = 8'd2,
    actRead       = 8'd3,
    actSize       = 8'd4,
    actInc        = 8'd5,
    actDec        = 8'd6,
    actIndex      = 8'd7,                             // Search for a value
    actPush       = 8'd14,
    actPop        = 8'd15,
    actResize     = 8'd17,
    actAlloc      = 8'd18,
    actFree       = 8'd19,
    actAdd        = 8'd20,                            // Returns new value
    actAddAfter   = 8'd21,                            // Returns old value
    actSubtract   = 8'd22,
    actSubAfter   = 8'd23,
    actShiftLeft  = 8'd24,
    actShiftRight = 8'd25,
    actNot        = 8'd27,                            // Bitwise
    actOr         = 8'd28,
    actXor        = 8'd29,
    actAnd        = 8'd30
  } actionT;

  typedef enum logic [3:0] {
    errNone,
    errNotAllocated,                                  // Above fresh counter
    errFreed,                                         // Flag clear
    errOutOfBounds,
    errFull,
    errEmpty,
    errTooLarge,                                      // Resize above length
    errOutOfMemory,
    errBadAction
  } errorT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluShl, aluShr,
    aluBitNot, aluBitOr, aluBitXor, aluBitAnd,
    aluEqual                                          // Scan compare
  } aluOpT;

endpackage

`default_nettype wire

// ==== hw/heapIfs.sv ====
/*
  Port bundles between the heap control and its storage:
  a small per-array table and the element store
*/
`timescale 1ns/1ps
`default_nettype none

// ------------------------------
// Table port, one per slot table
interface tableIf import heapPkg::*; #(parameter type entryT = logic) ();
  arrayIdT readAddr;                                  // Combinational read
  entryT   readData;
  logic    writeEnable;                               // Write on rising edge
  arrayIdT writeAddr;
  entryT   writeData;

  modport control (output readAddr, output writeEnable, output writeAddr,
                   output writeData, input readData);
  modport slots (input readAddr, input writeEnable, input writeAddr,
                 input writeData, output readData);
endinterface

// ------------------------------
// Element store port
interface storeIf import heapPkg::*; ();
  arrayIdT arrayId;                                   // Shared by read and write
  indexT   index;
  dataT    readData;                                  // Combinational
  logic    writeEnable;
  dataT    writeData;

  modport control (output arrayId, output index, output writeEnable,
                   output writeData, input readData);
  modport store (input arrayId, input index, input writeEnable,
                 input writeData, output readData);
endinterface

`default_nettype wire

// ==== hw/elementAlu.sv ====
/*
  Element ALU: arithmetic, shifts, bitwise logic and the
  equality compare used by the Index scan
*/
`timescale 1ns/1ps
`default_nettype none

module elementAlu import heapPkg::*; (
  input  aluOpT op,
  input  dataT  a,                                    // Stored element
  input  dataT  b,                                    // Command data
  output dataT  result,
  output logic  match
);

  assign match = (a == b);                            // Scan hit

  // ------------------------------
  // Operation select
  always_comb begin
    case (op)
      aluAdd:    result = a + b;                      // Wraps at 16 bits
      aluSub:    result = a - b;
      aluShl:    result = a << b;
      aluShr:    result = a >> b;                     // Logical
      aluBitNot: result = ~a;
      aluBitOr:  result = a | b;
      aluBitXor: result = a ^ b;
      aluBitAnd: result = a & b;
      aluEqual:  result = dataT'(match);
      default:   result = '0;
    endcase
    // Control always presents a decoded op
    assert #0 (!$isunknown(op)) else $error("ALU op unknown");
  end

endmodule

`default_nettype wire

// ==== hw/elementStore.sv ====
/*
  Element store: every element of every array in one block,
  combinational read, write on the rising edge
*/
`timescale 1ns/1ps
`default_nettype none

module elementStore import heapPkg::*; (
  input logic   clock,
  storeIf.store store
);

  // ------------------------------
  // Storage
  dataT memory [ARRAYS][ARRAY_LENGTH];                // Fixed block per array

  assign store.readData = memory[store.arrayId][store.index];

  always_ff @(posedge clock) begin
    if (store.writeEnable) begin
      memory[store.arrayId][store.index] <= store.writeData;
    end
  end

  // ------------------------------
  // Checks
  // Control must settle the address before any write
  assert property (@(posedge clock) store.writeEnable |-> !$isunknown(store.index));

  assert property (@(posedge clock) store.writeEnable |-> !$isunknown(store.arrayId));

endmodule

`default_nettype wire

// ==== hw/slotTable.sv ====
/*
  Per-array slot table, one entry per array number,
  cleared on reset; serves sizes, flags and the freed stack
*/
`timescale 1ns/1ps
`default_nettype none

module slotTable import heapPkg::*; #(
  parameter type entryT = logic                       // Payload of one slot
) (
  input logic   clock,
  input logic   resetN,
  tableIf.slots port
);

  entryT entries [ARRAYS];

  assign port.readData = entries[port.readAddr];      // Same-cycle read

  // ------------------------------
  // Write port
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < ARRAYS; i++) begin
        entries[i] <= '0;                             // Empty table
      end
    end else if (port.writeEnable) begin
      entries[port.writeAddr] <= port.writeData;
    end
  end

endmodule

`default_nettype wire

// ==== hw/heapControl.sv ====
/*
  Heap command sequencer: latches a command, checks access,
  scans for Index, then writes the tables and reports
*/
`timescale 1ns/1ps
`default_nettype none

module heapControl import heapPkg::*; (
  input  logic    clock,
  input  logic    resetN,
  input  logic    start,
  input  actionT  action,
  input  arrayIdT arrayId,
  input  indexT   index,
  input  dataT    dataIn,
  output dataT    dataOut,
  output errorT   error,
  output logic    busy,
  output logic    done,
  tableIf.control sizes,
  tableIf.control flags,
  tableIf.control freed,
  storeIf.control store,
  output aluOpT   aluOp,
  output dataT    aluA,
  output dataT    aluB,
  input  dataT    aluResult,
  input  logic    aluMatch
);

  typedef enum logic [1:0] {stIdle, stCheck, stScan, stFinish} stateT;

  stateT                 state;
  logic [ADDRESS_BITS:0] freshCount;                  // Arrays handed out so far
  logic [ADDRESS_BITS:0] freedTop;                    // Freed stack depth
  errorT                 pendError;                   // Verdict of check step
  actionT                cmdAction;                   // Latched command
  arrayIdT               cmdArray;
  indexT                 cmdIndex;
  dataT                  cmdData;
  indexT                 elemIndex;                   // Element touched in finish
  sizeT                  newSize;
  arrayIdT               target;                      // Alloc id or command array
  dataT                  pendResult;
  indexT                 scanPos;
  sizeT                  lastMatch;                   // Position+1, 0 if none
  sizeT                  curSize;
  sizeT                  scanNext;
  logic                  scanLast;
  logic                  readType;
  logic                  commit;
  errorT                 accessError;
  errorT                 checkError;
  indexT                 nextIndex;
  sizeT                  nextSize;
  arrayIdT               nextTarget;
  dataT                  nextResult;
  dataT                  resultValue;
  logic                  returnsValue;

  assign curSize  = sizes.readData;
  assign scanNext = {1'b0, scanPos} + sizeT'(1);
  assign scanLast = (scanNext == curSize);            // Last live element
  assign readType = cmdAction inside {actRead, actAdd, actAddAfter, actSubtract, actSubAfter,
                                      actShiftLeft, actShiftRight, actNot, actOr, actXor,
                                      actAnd};
  assign commit   = (state == stFinish) && (pendError == errNone);

  // ------------------------------
  // Access and action checks
  always_comb begin
    accessError = errNone;
    if ({1'b0, cmdArray} >= freshCount) accessError = errNotAllocated;
    else if (!flags.readData) accessError = errFreed;
    else if (readType && ({1'b0, cmdIndex} >= curSize)) accessError = errOutOfBounds;
  end

  always_comb begin
    checkError = accessError;
    nextIndex  = cmdIndex;
    nextSize   = curSize;
    nextTarget = cmdArray;
    nextResult = cmdData;                             // Write echoes its data
    case (cmdAction)
      actReset: checkError = errNone;                 // No array involved
      actWrite: if ({1'b0, cmdIndex} >= curSize) nextSize = {1'b0, cmdIndex} + sizeT'(1);
      actSize:  nextResult = dataT'(curSize);
      actInc: begin
        if (accessError == errNone && curSize == sizeT'(ARRAY_LENGTH)) checkError = errFull;
        nextSize = curSize + sizeT'(1);
      end
      actDec: begin
        if (accessError == errNone && curSize == '0) checkError = errEmpty;
        nextSize = curSize - sizeT'(1);
      end
      actPush: begin
        if (accessError == errNone && curSize == sizeT'(ARRAY_LENGTH)) checkError = errFull;
        nextIndex = curSize[INDEX_BITS-1:0];          // Slot past the end
        nextSize  = curSize + sizeT'(1);
      end
      actPop: begin
        if (accessError == errNone && curSize == '0) checkError = errEmpty;
        nextSize  = curSize - sizeT'(1);
        nextIndex = nextSize[INDEX_BITS-1:0];         // Last element
      end
      actResize: begin
        if (accessError == errNone && cmdData > dataT'(ARRAY_LENGTH)) checkError = errTooLarge;
        nextSize = cmdData[INDEX_BITS:0];
      end
      actAlloc: begin
        checkError = errNone;
        if (freedTop != '0) nextTarget = freed.readData;         // Reuse freed number
        else if (freshCount < ARRAYS) nextTarget = freshCount[ADDRESS_BITS-1:0];
        else checkError = errOutOfMemory;
        nextSize   = '0;
        nextResult = dataT'(nextTarget);
      end
      actRead, actIndex, actFree, actAdd, actAddAfter, actSubtract, actSubAfter,
      actShiftLeft, actShiftRight, actNot, actOr, actXor, actAnd: ;
      default: checkError = errBadAction;
    endcase
  end

  // ------------------------------
  // Storage and ALU drive
  always_comb begin
    store.arrayId     = cmdArray;
    store.index       = (state == stScan) ? scanPos : elemIndex;
    store.writeEnable = commit && (cmdAction inside {actWrite, actPush, actAdd, actAddAfter,
                        actSubtract, actSubAfter, actShiftLeft, actShiftRight, actNot, actOr,
                        actXor, actAnd});
    store.writeData   = (cmdAction inside {actWrite, actPush}) ? cmdData : aluResult;
    sizes.readAddr    = cmdArray;
    sizes.writeAddr   = target;
    sizes.writeData   = newSize;
    sizes.writeEnable = commit && (cmdAction inside {actWrite, actInc, actDec, actPush,
                        actPop, actResize, actAlloc});
    flags.readAddr    = cmdArray;
    flags.writeAddr   = target;
    flags.writeData   = (cmdAction == actAlloc);      // Set on Alloc, clear on Free
    flags.writeEnable = commit && (cmdAction inside {actAlloc, actFree});
    freed.readAddr    = arrayIdT'(freedTop - 1'b1);   // Top of stack
    freed.writeAddr   = freedTop[ADDRESS_BITS-1:0];
    freed.writeData   = cmdArray;
    freed.writeEnable = commit && (cmdAction == actFree);
  end

  assign aluA = store.readData;
  assign aluB = cmdData;

  always_comb begin
    if (state == stScan) aluOp = aluEqual;
    else begin
      case (cmdAction)
        actSubtract, actSubAfter: aluOp = aluSub;
        actShiftLeft:             aluOp = aluShl;
        actShiftRight:            aluOp = aluShr;
        actNot:                   aluOp = aluBitNot;
        actOr:                    aluOp = aluBitOr;
        actXor:                   aluOp = aluBitXor;
        actAnd:                   aluOp = aluBitAnd;
        default:                  aluOp = aluAdd;
      endcase
    end
  end

  always_comb begin
    resultValue  = pendResult;
    returnsValue = 1'b1;
    case (cmdAction)
      actWrite, actSize, actAlloc: resultValue = pendResult;
      actRead, actPop, actAddAfter, actSubAfter: resultValue = store.readData;  // Old value
      actIndex: resultValue = dataT'(lastMatch);
      actAdd, actSubtract, actShiftLeft, actShiftRight, actNot, actOr, actXor, actAnd:
        resultValue = aluResult;
      default: returnsValue = 1'b0;
    endcase
  end

  // ------------------------------
  // Sequencer
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state      <= stIdle;
      busy       <= 1'b0;
      done       <= 1'b0;
      dataOut    <= '0;
      error      <= errNone;
      pendError  <= errNone;
      freshCount <= '0;
      freedTop   <= '0;
    end else begin
      done <= 1'b0;                                   // One-cycle pulse
      case (state)
        stIdle: if (start) begin
          busy  <= 1'b1;
          state <= stCheck;
        end
        stCheck: begin
          pendError <= checkError;
          if (checkError == errNone && cmdAction == actIndex && curSize != '0) state <= stScan;
          else state <= stFinish;
        end
        stScan: if (scanLast) state <= stFinish;
        default: begin                                // Finish, write and report
          state <= stIdle;
          busy  <= 1'b0;
          done  <= 1'b1;
          error <= pendError;
          if (pendError == errNone) begin
            if (returnsValue) dataOut <= resultValue;
            if (cmdAction == actReset) begin
              freshCount <= '0;
              freedTop   <= '0;
            end
            if (cmdAction == actFree) freedTop <= freedTop + 1'b1;
            if (cmdAction == actAlloc) begin
              if (freedTop != '0) freedTop <= freedTop - 1'b1;
              else freshCount <= freshCount + 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == stIdle && start) begin               // Accept command
      cmdAction <= action;
      cmdArray  <= arrayId;
      cmdIndex  <= index;
      cmdData   <= dataIn;
    end
    if (state == stCheck) begin
      elemIndex  <= nextIndex;
      newSize    <= nextSize;
      target     <= nextTarget;
      pendResult <= nextResult;
      scanPos    <= '0;
      lastMatch  <= '0;
    end
    if (state == stScan) begin
      scanPos <= scanPos + 1'b1;
      if (aluMatch) lastMatch <= scanNext;            // Later hits win
    end
  end

  // Done only closes a command that was in flight
  assert property (@(posedge clock) disable iff (!resetN) done |-> $past(busy));

endmodule

`default_nettype wire

// ==== hw/arrayHeap.sv ====
/*
  Array heap top level: command sequencer, element store,
  size, flag and freed-stack tables and the element ALU
*/
`timescale 1ns/1ps
`default_nettype none

module arrayHeap import heapPkg::*; (
  input  logic    clock,
  input  logic    resetN,
  input  logic    start,                              // Command strobe
  input  actionT  action,
  input  arrayIdT arrayId,
  input  indexT   index,
  input  dataT    dataIn,
  output dataT    dataOut,
  output errorT   error,
  output logic    busy,
  output logic    done                                // Result valid
);

  // ------------------------------
  // Internal buses
  tableIf #(.entryT(sizeT))    sizeBus ();
  tableIf #(.entryT(logic))    flagBus ();
  tableIf #(.entryT(arrayIdT)) freedBus ();           // Addressed by stack slot
  storeIf                      storeBus ();

  aluOpT aluOp;
  dataT  aluA;
  dataT  aluB;
  dataT  aluResult;
  logic  aluMatch;

  // ------------------------------
  // Control
  heapControl control0 (
    .clock     (clock),
    .resetN    (resetN),
    .start     (start),
    .action    (action),
    .arrayId   (arrayId),
    .index     (index),
    .dataIn    (dataIn),
    .dataOut   (dataOut),
    .error     (error),
    .busy      (busy),
    .done      (done),
    .sizes     (sizeBus),
    .flags     (flagBus),
    .freed     (freedBus),
    .store     (storeBus),
    .aluOp     (aluOp),
    .aluA      (aluA),
    .aluB      (aluB),
    .aluResult (aluResult),
    .aluMatch  (aluMatch)
  );

  // ------------------------------
  // Datapath
  elementStore store0 (
    .clock (clock),
    .store (storeBus)
  );

  slotTable #(.entryT(sizeT)) sizeTable (
    .clock  (clock),
    .resetN (resetN),
    .port   (sizeBus)
  );

  slotTable #(.entryT(logic)) flagTable (              // Allocation flags
    .clock  (clock),
    .resetN (resetN),
    .port   (flagBus)
  );

  slotTable #(.entryT(arrayIdT)) freedStack (
    .clock  (clock),
    .resetN (resetN),
    .port   (freedBus)
  );

  elementAlu alu0 (
    .op     (aluOp),
    .a      (aluA),
    .b      (aluB),
    .result (aluResult),
    .match  (aluMatch)
  );

endmodule

`default_nettype wire

// ==== testbench/heapTb.sv ====
/*
  Array heap testbench: reads command vectors from the test file,
  drives them into the heap and checks data and error results
*/
`timescale 1ns/1ps
`default_nettype none

module heapTb import heapPkg::*; ();

  localparam int TIMEOUT_CYCLES = 100;                // Limit for every wait
  localparam int RESET_CYCLES   = 16;
  localparam int FIXED_LATENCY  = 2;                  // Accept edge to done edge

  // ------------------------------
  // DUT signals
  logic    clock;
  logic    resetN;
  logic    start;
  actionT  action;
  arrayIdT arrayId;
  indexT   index;
  dataT    dataIn;
  dataT    dataOut;
  errorT   error;
  logic    busy;
  logic    done;

  int   testCount;                                    // Vectors run
  int   passCount;
  int   failCount;
  int   mismatchCount;                                // Running total of bad compares
  logic aborted;                                      // Timeout or missing file

  arrayHeap dut0 (
    .clock   (clock),
    .resetN  (resetN),
    .start   (start),
    .action  (action),
    .arrayId (arrayId),
    .index   (index),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .error   (error),
    .busy    (busy),
    .done    (done)
  );

  always #50 clock = ~clock;                          // 100 ns period

  // ------------------------------
  // Result compares
  task automatic checkData(input string name, input dataT expected, input dataT actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic checkError(input errorT expected, input errorT actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: error expected %0d (%s), actual %0d (%s)",
               $time, expected, expected.name(), actual, actual.name());
      mismatchCount++;
    end
  endtask

  task automatic checkLevel(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %b, actual %b", $time, name, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic checkLatency(input int expected, input int actual);
    if (actual != expected) begin
      $display("MISMATCH at %0t: latency expected %0d, actual %0d", $time, expected, actual);
      mismatchCount++;
    end
  endtask

  // ------------------------------
  // Command handshake
  task automatic waitIdle();
    int cycles;
    cycles = 0;
    while (busy && cycles < TIMEOUT_CYCLES) begin     // Ends on a falling edge
      @(negedge clock);
      cycles++;
    end
    if (busy) begin
      $display("ERROR at %0t: heap stayed busy for %0d cycles", $time, TIMEOUT_CYCLES);
      aborted = 1'b1;
    end
  endtask

  task automatic issueCommand(input int code, input int arr, input int idx, input int data,
                              output int cycles);
    cycles = 0;
    waitIdle();
    if (!aborted) begin
      action  = actionT'(8'(code));                   // Unknown codes pass through
      arrayId = arrayIdT'(arr);
      index   = indexT'(idx);
      dataIn  = dataT'(data);
      start   = 1'b1;
      @(negedge clock);
      start   = 1'b0;                                 // One-cycle strobe
      checkLevel("busy", 1'b1, busy);                 // Raised by the accept edge
      checkLevel("done", 1'b0, done);
      while (!done && cycles < TIMEOUT_CYCLES) begin
        @(negedge clock);
        cycles++;
      end
      if (!done) begin
        $display("ERROR at %0t: no done within %0d cycles for action %0d",
                 $time, TIMEOUT_CYCLES, code);
        aborted = 1'b1;
      end else begin
        checkLevel("busy", 1'b0, busy);               // Falls with done
      end
    end
  endtask

  // ------------------------------
  // Vector loop
  initial begin
    int    fileId;
    string line;
    int    fields;
    int    vecAction;
    int    vecArray;
    int    vecIndex;
    int    vecData;
    int    expData;
    int    expError;
    int    checkFlag;
    int    mismatchesBefore;
    int    latency;
    logic  testBad;
    dataT  heldData;

    clock         = 1'b0;
    resetN        = 1'b0;                             // Held in reset
    start         = 1'b0;
    action        = actRead;
    arrayId       = '0;
    index         = '0;
    dataIn        = '0;
    testCount     = 0;
    passCount     = 0;
    failCount     = 0;
    mismatchCount = 0;
    aborted       = 1'b0;
    heldData      = '0;                               // Output value after reset

    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    @(negedge clock);

    // Idle outputs after reset
    checkData("dataOut", '0, dataOut);
    checkError(errNone, error);
    checkLevel("busy", 1'b0, busy);
    checkLevel("done", 1'b0, done);

    fileId = $fopen("testbench/heapTests.txt", "r");
    if (fileId == 0) begin
      $display("ERROR: cannot open testbench/heapTests.txt");
      aborted = 1'b1;
    end else begin
      while (!aborted && $fgets(line, fileId) != 0) begin
        if (line.len() > 0 && line.getc(0) != "#") begin     // Skip column notes
          fields = $sscanf(line, "%d %d %d %h %h %d %d", vecAction, vecArray, vecIndex,
                           vecData, expData, expError, checkFlag);
          if (fields == 7) begin
            mismatchesBefore = mismatchCount;
            issueCommand(vecAction, vecArray, vecIndex, vecData, latency);
            if (!aborted) begin
              checkError(errorT'(4'(expError)), error);       // Sampled while done is high
              if (checkFlag != 0) begin
                checkData("dataOut", dataT'(expData), dataOut);
                heldData = dataT'(expData);
              end else begin
                checkData("dataOut", heldData, dataOut);      // No value, output holds
              end
              if (vecAction != int'(actIndex)) checkLatency(FIXED_LATENCY, latency);
            end
            testCount++;
            testBad = aborted || (mismatchCount != mismatchesBefore);
            if (testBad) failCount++;
            else passCount++;
            $display("test %0d: action %0d array %0d index %0d data %h: %s", testCount,
                     vecAction, vecArray, vecIndex, dataT'(vecData), testBad ? "bad" : "ok");
          end
        end
      end
      $fclose(fileId);
    end

    if (testCount == 0) begin
      $display("ERROR: no test vectors were read");
      aborted = 1'b1;
    end

    $display("%0d tests run, %0d passed, %0d failed", testCount, passCount, failCount);
    if (failCount == 0 && mismatchCount == 0 && !aborted) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/heapTests.txt ====
# action arrayId index dataIn(hex) expectedData(hex) expectedError checkData
# action and error are decimal heapPkg codes; checkData 1 compares dataOut
# Allocation, reuse and freeing
18 0 0 0000 0000 0 1
18 0 0 0000 0001 0 1
18 0 0 0000 0002 0 1
19 1 0 0000 0000 0 0
19 1 0 0000 0000 2 0
18 0 0 0000 0001 0 1
3 5 0 0000 0000 1 0
2 6 0 0000 0000 1 0
# Write, Size and Read on array 0
2 0 0 1111 1111 0 1
2 0 1 2222 2222 0 1
2 0 2 3333 3333 0 1
4 0 0 0000 0003 0 1
3 0 0 0000 1111 0 1
3 0 2 0000 3333 0 1
3 0 5 0000 0000 3 0
# Push, Pop, Inc, Dec and Resize on array 1
2 1 5 0006 0006 0 1
14 1 0 0007 0000 0 0
14 1 0 0008 0000 0 0
4 1 0 0000 0008 0 1
14 1 0 0009 0000 4 0
5 1 0 0000 0000 4 0
15 1 0 0000 0008 0 1
15 1 0 0000 0007 0 1
15 1 0 0000 0006 0 1
17 1 0 0000 0000 0 0
15 1 0 0000 0000 5 0
6 1 0 0000 0000 5 0
17 1 0 0009 0000 6 0
17 1 0 0004 0000 0 0
4 1 0 0000 0004 0 1
5 1 0 0000 0000 0 0
4 1 0 0000 0005 0 1
# Index search on array 2
2 2 0 000a 000a 0 1
2 2 1 0014 0014 0 1
2 2 2 001e 001e 0 1
7 2 0 0014 0002 0 1
7 2 0 0063 0000 0 1
# Fill the remaining array numbers
18 0 0 0000 0003 0 1
18 0 0 0000 0004 0 1
18 0 0 0000 0005 0 1
18 0 0 0000 0006 0 1
18 0 0 0000 0007 0 1
18 0 0 0000 0000 7 0
# Element arithmetic on array 0 index 0, starting at 1111
20 0 0 f000 0111 0 1
22 0 0 0112 ffff 0 1
24 0 0 0004 fff0 0 1
25 0 0 0008 00ff 0 1
27 0 0 0000 ff00 0 1
28 0 0 0f0f ff0f 0 1
29 0 0 ffff 00f0 0 1
30 0 0 0030 0030 0 1
21 0 0 0005 0030 0 1
3 0 0 0000 0035 0 1
23 0 0 0036 0035 0 1
3 0 0 0000 ffff 0 1
20 0 3 0001 0000 3 0
# Unknown action, counter reset
8 0 0 0000 0000 8 0
1 0 0 0000 0000 0 0
18 0 0 0000 0000 0 1
3 1 0 0000 0000 1 0

// ==== vlog.f ====
hw/heapPkg.sv
hw/heapIfs.sv
hw/elementAlu.sv
hw/elementStore.sv
hw/slotTable.sv
hw/heapControl.sv
hw/arrayHeap.sv
testbench/heapTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the array heap testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module heapTb \
  -Mdir "$BUILD_DIR" -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/VheapTb" > "$LOG_FILE" 2>&1
runStatus=$?
cat "$LOG_FILE"
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -qx "TEST PASSED" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
fi

echo "Pass message not found in $LOG_FILE"
exit 1
